// ==== verilog/bpf_pkg.sv ====
package bpf_pkg;

    // Load size field, same coding as the size bits of a BPF load opcode
    // Value 3 has no meaning and is never issued
    typedef enum logic [1:0] {
        BPF_W = 2'd0,
        BPF_H = 2'd1,
        BPF_B = 2'd2
    } xfer_sz_t;

    // Bits per packet byte
    localparam int BYTE_WIDTH = 8;

    // Width of every load result handed to a filter CPU
    localparam int LOAD_WIDTH = 32;

    // Number of packet bytes covered by one load
    function automatic logic [2:0] xfer_bytes(xfer_sz_t sz);
        logic [2:0] n;
        case (sz)
            BPF_W: n = 3'd4;
            BPF_H: n = 3'd2;
            BPF_B: n = 3'd1;
            // Illegal size, counts as a full word so the bound check stays safe
            default: n = 3'd4;
        endcase
        return n;
    endfunction

endpackage

// ==== verilog/bpf_ifs.sv ====
// Packet write bus, broadcast from the writer to every lane copy
interface pkt_wr_if #(
    parameter int BYTE_ADDR_WIDTH = 12,
    parameter int ADDR_WIDTH = 9,
    parameter int PLEN_WIDTH = 16
);
    import bpf_pkg::*;

    // One memory word holds 2^(byte addr bits - word addr bits) bytes
    localparam int WORD_WIDTH = BYTE_WIDTH * (2 ** (BYTE_ADDR_WIDTH - ADDR_WIDTH));

    logic wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [WORD_WIDTH-1:0] wr_data;
    // Committed packet length, valid once len_vld is up
    logic [PLEN_WIDTH-1:0] byte_len;
    logic len_vld;

    modport source (output wr_en, wr_addr, wr_data, byte_len, len_vld);
    modport sink (input wr_en, wr_addr, wr_data, byte_len, len_vld);
endinterface

// Load result of one lane, read by the collector
interface load_res_if;
    import bpf_pkg::*;

    // vld is a single-cycle strobe qualifying data and oob
    logic vld;
    logic [LOAD_WIDTH-1:0] data;
    logic oob;
    // High while a load is inside the lane
    logic pending;

    modport lane (output vld, data, oob, pending);
    modport drain (input vld, data, oob, pending);
endinterface

// ==== verilog/pkt_writer.sv ====
module pkt_writer #(
    parameter int BYTE_ADDR_WIDTH = 12,
    parameter int ADDR_WIDTH = 9,
    parameter int PLEN_WIDTH = 16,
    localparam int OFF_WIDTH = BYTE_ADDR_WIDTH - ADDR_WIDTH,
    localparam int WORD_WIDTH = bpf_pkg::BYTE_WIDTH * (2 ** OFF_WIDTH)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_word_en_i,
    input  logic [WORD_WIDTH-1:0] wr_word_i,
    input  logic                  wr_last_i,
    input  logic [PLEN_WIDTH-1:0] wr_bytes_i,
    pkt_wr_if.source              wr
);

    logic [ADDR_WIDTH-1:0] addr_q;
    logic [PLEN_WIDTH-1:0] len_q;
    logic len_vld_q;
    logic commit;
    // Bytes covered by the words written so far, this word included
    logic [BYTE_ADDR_WIDTH:0] bytes_written;

    // Last word closes the packet at the same edge it is written
    assign commit = wr_word_en_i & wr_last_i;

    // Word address counter, rewinds on commit
    always_ff @(posedge clk) begin
        if (!rst) begin
            addr_q <= '0;
            len_vld_q <= 1'b0;
        end else if (commit) begin
            addr_q <= '0;
            len_vld_q <= 1'b1;
        end else if (wr_word_en_i) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    // Length held until the next commit
    always_ff @(posedge clk) begin
        if (commit) begin
            len_q <= wr_bytes_i;
        end
    end

    // Write goes straight to the lane memories at the next edge
    assign wr.wr_en = wr_word_en_i;
    assign wr.wr_addr = addr_q;
    assign wr.wr_data = wr_word_i;
    assign wr.byte_len = len_q;
    assign wr.len_vld = len_vld_q;

    assign bytes_written = {({1'b0, addr_q} + 1'b1), {OFF_WIDTH{1'b0}}};

    // Committed length must lie inside the words actually written
    a_len_fits: assert property (@(posedge clk) disable iff (!rst)
        commit |-> (wr_bytes_i <= bytes_written))
        else $error("packet length %0d exceeds %0d bytes written", wr_bytes_i, bytes_written);

endmodule

// ==== verilog/packet_ram.sv ====
module packet_ram #(
    parameter int BYTE_ADDR_WIDTH = 12,
    parameter int ADDR_WIDTH = 9,
    localparam int WORD_WIDTH = bpf_pkg::BYTE_WIDTH * (2 ** (BYTE_ADDR_WIDTH - ADDR_WIDTH))
) (
    input  logic                  clk,
    pkt_wr_if.sink                wr,
    input  logic [ADDR_WIDTH-1:0] rd_addr_i,
    output logic [WORD_WIDTH-1:0] rd_word_o
);

    // Big-endian words, byte 0 of a word sits in the top bits
    logic [WORD_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // Single write port from the broadcast bus
    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            mem[wr.wr_addr] <= wr.wr_data;
        end
    end

    // Registered read, one cycle of latency
    // Same-address write in the same cycle returns the old word
    always_ff @(posedge clk) begin
        rd_word_o <= mem[rd_addr_i];
    end

endmodule

// ==== verilog/load_adapter.sv ====
module load_adapter #(
    parameter int BYTE_ADDR_WIDTH = 12,
    parameter int ADDR_WIDTH = 9,
    parameter int PLEN_WIDTH = 16,
    parameter int PESS = 0,
    localparam int OFF_WIDTH = BYTE_ADDR_WIDTH - ADDR_WIDTH,
    localparam int WORD_WIDTH = bpf_pkg::BYTE_WIDTH * (2 ** OFF_WIDTH)
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rd_en_i,
    input  logic [BYTE_ADDR_WIDTH-1:0] rd_addr_i,
    input  bpf_pkg::xfer_sz_t          rd_size_i,
    input  logic [PLEN_WIDTH-1:0]      byte_len_i,
    output logic [ADDR_WIDTH-1:0]      word_addr_o,
    input  logic [WORD_WIDTH-1:0]      word_i,
    load_res_if.lane                   res
);
    import bpf_pkg::*;

    localparam int WORD_BYTES = 2 ** OFF_WIDTH;
    // Wide enough for address plus size against the length without wrap
    localparam int SUM_WIDTH = ((BYTE_ADDR_WIDTH > PLEN_WIDTH) ? BYTE_ADDR_WIDTH : PLEN_WIDTH) + 1;

    logic [OFF_WIDTH-1:0] offset;
    logic [2:0] nbytes;
    logic [SUM_WIDTH-1:0] end_addr;
    logic crosses;
    logic oob;
    logic [OFF_WIDTH-1:0] off_q;
    xfer_sz_t size_q;
    logic vld_q;
    logic oob_q;
    logic [WORD_WIDTH-1:0] shifted;
    logic [LOAD_WIDTH-1:0] sel;
    logic [LOAD_WIDTH-1:0] data;

    // Issue cycle, word address goes to the RAM right away
    assign word_addr_o = rd_addr_i[BYTE_ADDR_WIDTH-1:OFF_WIDTH];
    assign offset = rd_addr_i[OFF_WIDTH-1:0];
    assign nbytes = xfer_bytes(rd_size_i);

    // Bound check against the committed packet length
    assign end_addr = SUM_WIDTH'(rd_addr_i) + SUM_WIDTH'(nbytes);
    // Load spilling into the next word cannot be served from one read
    assign crosses = ({1'b0, offset} + (OFF_WIDTH+1)'(nbytes)) > (OFF_WIDTH+1)'(WORD_BYTES);
    assign oob = (end_addr > SUM_WIDTH'(byte_len_i)) | crosses;

    // Valid bit follows the RAM latency
    always_ff @(posedge clk) begin
        if (!rst) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= rd_en_i;
        end
    end

    // Offset, size and flag ride alongside the RAM read
    always_ff @(posedge clk) begin
        off_q <= offset;
        size_q <= rd_size_i;
        oob_q <= oob;
    end

    // Move the addressed byte to the top, zeros shift in from below
    assign shifted = word_i << {off_q, 3'b000};
    assign sel = shifted[WORD_WIDTH-1 -: LOAD_WIDTH];

    // Right-align the requested bytes, zero padding on the left
    always_comb begin
        case (size_q)
            BPF_W: data = sel;
            BPF_H: data = LOAD_WIDTH'(sel[LOAD_WIDTH-1 -: 2*BYTE_WIDTH]);
            default: data = LOAD_WIDTH'(sel[LOAD_WIDTH-1 -: BYTE_WIDTH]);
        endcase
        // Out-of-bounds loads read as zero
        if (oob_q) begin
            data = '0;
        end
    end

    if (PESS != 0) begin : g_pess
        // Extra output stage for timing
        always_ff @(posedge clk) begin
            if (!rst) begin
                res.vld <= 1'b0;
                res.data <= '0;
                res.oob <= 1'b0;
            end else begin
                res.vld <= vld_q;
                res.data <= data;
                res.oob <= oob_q;
            end
        end
    end else begin : g_direct
        assign res.vld = vld_q;
        assign res.data = data;
        assign res.oob = oob_q;
    end

    a_size_legal: assert property (@(posedge clk) disable iff (!rst)
        rd_en_i |-> rd_size_i inside {BPF_W, BPF_H, BPF_B})
        else $error("illegal load size %0d", rd_size_i);

    // A word load must fit inside one memory word
    a_word_fits: assert property (@(posedge clk) disable iff (!rst)
        (rd_en_i && rd_size_i == BPF_W) |-> !crosses)
        else $error("word load at offset %0d crosses the word end", offset);

endmodule

// ==== verilog/read_lane.sv ====
module read_lane #(
    parameter int BYTE_ADDR_WIDTH = 12,
    parameter int ADDR_WIDTH = 9,
    parameter int PLEN_WIDTH = 16,
    parameter int PESS = 0
) (
    input  logic                       clk,
    input  logic                       rst,
    pkt_wr_if.sink                     wr,
    input  logic                       rd_en_i,
    input  logic [BYTE_ADDR_WIDTH-1:0] rd_addr_i,
    input  bpf_pkg::xfer_sz_t          rd_size_i,
    load_res_if.lane                   res
);
    import bpf_pkg::*;

    localparam int WORD_WIDTH = BYTE_WIDTH * (2 ** (BYTE_ADDR_WIDTH - ADDR_WIDTH));

    logic [ADDR_WIDTH-1:0] word_addr;
    logic [WORD_WIDTH-1:0] word;
    logic [PLEN_WIDTH-1:0] eff_len;
    // Loads between issue and result, at most 1 + PESS
    logic [1:0] inflight_q;

    // No packet committed yet means every load is out of bounds
    assign eff_len = wr.len_vld ? wr.byte_len : '0;

    // Private packet copy
    packet_ram #(
        .BYTE_ADDR_WIDTH(BYTE_ADDR_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_ram (
        .clk(clk),
        .wr(wr),
        .rd_addr_i(word_addr),
        .rd_word_o(word)
    );

    load_adapter #(
        .BYTE_ADDR_WIDTH(BYTE_ADDR_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .PLEN_WIDTH(PLEN_WIDTH),
        .PESS(PESS)
    ) u_adapter (
        .clk(clk),
        .rst(rst),
        .rd_en_i(rd_en_i),
        .rd_addr_i(rd_addr_i),
        .rd_size_i(rd_size_i),
        .byte_len_i(eff_len),
        .word_addr_o(word_addr),
        .word_i(word),
        .res(res)
    );

    // Up on issue, down when the result strobes out
    always_ff @(posedge clk) begin
        if (!rst) begin
            inflight_q <= '0;
        end else begin
            inflight_q <= inflight_q + 2'(rd_en_i) - 2'(res.vld);
        end
    end

    assign res.pending = (inflight_q != 2'd0);

endmodule

// ==== verilog/result_collector.sv ====
module result_collector #(
    parameter int NUM_LANES = 4,
    localparam int LANE_WIDTH = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
    input  logic                           clk,
    input  logic                           rst,
    load_res_if.drain                      res [NUM_LANES],
    output logic [NUM_LANES-1:0]           lane_busy_o,
    output logic                           out_vld_o,
    output logic [LANE_WIDTH-1:0]          out_lane_o,
    output logic [bpf_pkg::LOAD_WIDTH-1:0] out_data_o,
    output logic                           out_oob_o
);
    import bpf_pkg::*;

    logic [NUM_LANES-1:0] in_vld;
    logic [NUM_LANES-1:0] in_oob;
    logic [NUM_LANES-1:0] in_pend;
    logic [LOAD_WIDTH-1:0] in_data [NUM_LANES];
    // One holding slot per lane
    logic [NUM_LANES-1:0] full_q;
    logic [LOAD_WIDTH-1:0] data_q [NUM_LANES];
    logic [NUM_LANES-1:0] oob_q;
    // Last lane served, search starts just after it
    logic [LANE_WIDTH-1:0] last_q;
    logic [LANE_WIDTH-1:0] pick;
    logic pick_vld;
    logic [NUM_LANES-1:0] grant;

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign in_vld[g] = res[g].vld;
        assign in_oob[g] = res[g].oob;
        assign in_pend[g] = res[g].pending;
        assign in_data[g] = res[g].data;

        // Host keeps one load per lane, so a full slot is never hit
        a_no_overwrite: assert property (@(posedge clk) disable iff (!rst)
            in_vld[g] |-> (!full_q[g] || grant[g]))
            else $error("lane %0d result overwrote an undelivered one", g);
    end

    // Round robin, first full lane after last_q
    always_comb begin
        int idx;
        pick_vld = 1'b0;
        pick = '0;
        // Walk backwards so the nearest lane wins
        for (int k = NUM_LANES; k >= 1; k--) begin
            idx = (int'(last_q) + k) % NUM_LANES;
            if (full_q[idx]) begin
                pick_vld = 1'b1;
                pick = LANE_WIDTH'(idx);
            end
        end
    end

    assign grant = pick_vld ? (NUM_LANES'(1) << pick) : '0;

    // Served slot frees, arriving result fills
    always_ff @(posedge clk) begin
        if (!rst) begin
            full_q <= '0;
        end else begin
            full_q <= (full_q & ~grant) | in_vld;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (in_vld[i]) begin
                data_q[i] <= in_data[i];
                oob_q[i] <= in_oob[i];
            end
        end
    end

    // Registered output, one result per cycle at most
    always_ff @(posedge clk) begin
        if (!rst) begin
            out_vld_o <= 1'b0;
            // Lane 0 goes first after reset
            last_q <= LANE_WIDTH'(NUM_LANES - 1);
        end else begin
            out_vld_o <= pick_vld;
            if (pick_vld) begin
                last_q <= pick;
            end
        end
    end

    always_ff @(posedge clk) begin
        out_lane_o <= pick;
        out_data_o <= data_q[pick];
        out_oob_o <= oob_q[pick];
    end

    // Busy from issue until the result has left
    assign lane_busy_o = in_pend | full_q;

endmodule

// ==== verilog/bpf_read_array.sv ====
module bpf_read_array #(
    parameter int BYTE_ADDR_WIDTH = 12,
    parameter int ADDR_WIDTH = 9,
    parameter int PLEN_WIDTH = 16,
    parameter int NUM_LANES = 4,
    parameter int PESS = 0,
    localparam int WORD_WIDTH = bpf_pkg::BYTE_WIDTH * (2 ** (BYTE_ADDR_WIDTH - ADDR_WIDTH)),
    localparam int LANE_WIDTH = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
    input  logic                                      clk,
    input  logic                                      rst,
    // Host packet writes
    input  logic                                      wr_word_en_i,
    input  logic [WORD_WIDTH-1:0]                     wr_word_i,
    input  logic                                      wr_last_i,
    input  logic [PLEN_WIDTH-1:0]                     wr_bytes_i,
    // Per-lane load requests
    input  logic [NUM_LANES-1:0]                      rd_en_i,
    input  logic [NUM_LANES-1:0][BYTE_ADDR_WIDTH-1:0] rd_addr_i,
    input  bpf_pkg::xfer_sz_t [NUM_LANES-1:0]         rd_size_i,
    output logic [NUM_LANES-1:0]                      lane_busy_o,
    // Merged result stream
    output logic                                      out_vld_o,
    output logic [LANE_WIDTH-1:0]                     out_lane_o,
    output logic [bpf_pkg::LOAD_WIDTH-1:0]            out_data_o,
    output logic                                      out_oob_o
);

    // Shared by all lanes
    pkt_wr_if #(
        .BYTE_ADDR_WIDTH(BYTE_ADDR_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .PLEN_WIDTH(PLEN_WIDTH)
    ) wr_bus ();

    load_res_if res_bus [NUM_LANES] ();

    pkt_writer #(
        .BYTE_ADDR_WIDTH(BYTE_ADDR_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH),
        .PLEN_WIDTH(PLEN_WIDTH)
    ) u_writer (
        .clk(clk),
        .rst(rst),
        .wr_word_en_i(wr_word_en_i),
        .wr_word_i(wr_word_i),
        .wr_last_i(wr_last_i),
        .wr_bytes_i(wr_bytes_i),
        .wr(wr_bus)
    );

    // One lane per filter CPU
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        read_lane #(
            .BYTE_ADDR_WIDTH(BYTE_ADDR_WIDTH),
            .ADDR_WIDTH(ADDR_WIDTH),
            .PLEN_WIDTH(PLEN_WIDTH),
            .PESS(PESS)
        ) u_lane (
            .clk(clk),
            .rst(rst),
            .wr(wr_bus),
            .rd_en_i(rd_en_i[g]),
            .rd_addr_i(rd_addr_i[g]),
            .rd_size_i(rd_size_i[g]),
            .res(res_bus[g])
        );
    end

    result_collector #(
        .NUM_LANES(NUM_LANES)
    ) u_collector (
        .clk(clk),
        .rst(rst),
        .res(res_bus),
        .lane_busy_o(lane_busy_o),
        .out_vld_o(out_vld_o),
        .out_lane_o(out_lane_o),
        .out_data_o(out_data_o),
        .out_oob_o(out_oob_o)
    );

endmodule

// ==== testbench/tb_load_table.svh ====
`ifndef TB_LOAD_TABLE_SVH
`define TB_LOAD_TABLE_SVH

    // Columns: packet (0 = 1000 bytes of 7k+3, 1 = 600 bytes of 13k+5), lane,
    // byte address, size, expected data, expected oob
    localparam int NUM_ROWS = 28;

    load_row_t load_table [NUM_ROWS] = '{
        // All four lanes at once, one size each
        '{1'b0, 2'd0, 12'd0, BPF_W, 32'h030a1118, 1'b0},
        '{1'b0, 2'd1, 12'd0, BPF_H, 32'h0000030a, 1'b0},
        '{1'b0, 2'd2, 12'd0, BPF_B, 32'h00000003, 1'b0},
        '{1'b0, 2'd3, 12'd4, BPF_W, 32'h1f262d34, 1'b0},
        // Offsets across the first words
        '{1'b0, 2'd0, 12'd8, BPF_H, 32'h00003b42, 1'b0},
        '{1'b0, 2'd1, 12'd1, BPF_B, 32'h0000000a, 1'b0},
        '{1'b0, 2'd2, 12'd2, BPF_B, 32'h00000011, 1'b0},
        '{1'b0, 2'd3, 12'd3, BPF_B, 32'h00000018, 1'b0},
        '{1'b0, 2'd0, 12'd5, BPF_B, 32'h00000026, 1'b0},
        '{1'b0, 2'd1, 12'd6, BPF_B, 32'h0000002d, 1'b0},
        '{1'b0, 2'd2, 12'd7, BPF_B, 32'h00000034, 1'b0},
        '{1'b0, 2'd3, 12'd6, BPF_H, 32'h00002d34, 1'b0},
        '{1'b0, 2'd0, 12'd1, BPF_W, 32'h0a11181f, 1'b0},
        '{1'b0, 2'd1, 12'd3, BPF_H, 32'h0000181f, 1'b0},
        '{1'b0, 2'd2, 12'd12, BPF_W, 32'h575e656c, 1'b0},
        // Packet end at 1000
        '{1'b0, 2'd3, 12'd996, BPF_W, 32'h3f464d54, 1'b0},
        '{1'b0, 2'd0, 12'd998, BPF_H, 32'h00004d54, 1'b0},
        '{1'b0, 2'd1, 12'd999, BPF_B, 32'h00000054, 1'b0},
        '{1'b0, 2'd2, 12'd1000, BPF_B, 32'h00000000, 1'b1},
        '{1'b0, 2'd3, 12'd999, BPF_H, 32'h00000000, 1'b1},
        '{1'b0, 2'd0, 12'd4092, BPF_W, 32'h00000000, 1'b1},
        '{1'b0, 2'd1, 12'd997, BPF_H, 32'h0000464d, 1'b0},
        // Shorter second packet, new data and new limit
        '{1'b1, 2'd0, 12'd0, BPF_W, 32'h05121f2c, 1'b0},
        '{1'b1, 2'd1, 12'd596, BPF_W, 32'h49566370, 1'b0},
        '{1'b1, 2'd2, 12'd600, BPF_B, 32'h00000000, 1'b1},
        '{1'b1, 2'd3, 12'd998, BPF_H, 32'h00000000, 1'b1},
        '{1'b1, 2'd0, 12'd599, BPF_B, 32'h00000070, 1'b0},
        '{1'b1, 2'd1, 12'd2, BPF_B, 32'h0000001f, 1'b0}
    };

`endif

// ==== testbench/tb_bpf_read_array.sv ====
module tb_bpf_read_array;
    timeunit 1ns;
    timeprecision 1ps;
    import bpf_pkg::*;

    localparam int NUM_LANES = 4;
    localparam int NUM_RANDOM = 200;

    // One directed load and the result it must produce
    typedef struct packed {
        logic        pkt;
        logic [1:0]  lane;
        logic [11:0] addr;
        xfer_sz_t    size;
        logic [31:0] data;
        logic        oob;
    } load_row_t;

    `include "tb_load_table.svh"

    // Generous bound on the whole run, packet writes included
    localparam int MAX_CYCLES = 20 * (NUM_ROWS + NUM_RANDOM) + 1000;

    logic clk;
    logic rst;
    logic wr_word_en;
    logic [63:0] wr_word;
    logic wr_last;
    logic [15:0] wr_bytes;
    logic [NUM_LANES-1:0] rd_en;
    logic [NUM_LANES-1:0][11:0] rd_addr;
    xfer_sz_t [NUM_LANES-1:0] rd_size;
    logic [NUM_LANES-1:0] lane_busy;
    logic out_vld;
    logic [1:0] out_lane;
    logic [31:0] out_data;
    logic out_oob;

    // Expected {oob, data} per lane, oldest first
    logic [32:0] exp_q [NUM_LANES][$];
    // Lanes that took a load at the last edge
    logic [NUM_LANES-1:0] issued_q;
    // Packet currently in the lane memories
    logic cur_pkt;
    integer seed = 40121;
    int cycles = 0;
    int n_value_err = 0;
    int n_busy_err = 0;
    int n_count_err = 0;
    int n_checked = 0;

    bpf_read_array u_dut (
        .clk(clk),
        .rst(rst),
        .wr_word_en_i(wr_word_en),
        .wr_word_i(wr_word),
        .wr_last_i(wr_last),
        .wr_bytes_i(wr_bytes),
        .rd_en_i(rd_en),
        .rd_addr_i(rd_addr),
        .rd_size_i(rd_size),
        .lane_busy_o(lane_busy),
        .out_vld_o(out_vld),
        .out_lane_o(out_lane),
        .out_data_o(out_data),
        .out_oob_o(out_oob)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Packet byte k, two different fill rules
    function automatic logic [7:0] byte_of(input logic pkt, input int k);
        return pkt ? 8'((13 * k + 5) % 256) : 8'((7 * k + 3) % 256);
    endfunction

    function automatic int pkt_len(input logic pkt);
        return pkt ? 600 : 1000;
    endfunction

    // Reference load, big-endian bytes right-aligned, zero past the end
    function automatic logic [32:0] model_load(input logic pkt, input int addr,
                                               input xfer_sz_t sz);
        int n;
        logic [31:0] d;
        n = (sz == BPF_W) ? 4 : ((sz == BPF_H) ? 2 : 1);
        d = '0;
        if (addr + n > pkt_len(pkt)) begin
            return {1'b1, 32'h0};
        end
        for (int i = 0; i < n; i++) begin
            d = {d[23:0], byte_of(pkt, addr + i)};
        end
        return {1'b0, d};
    endfunction

    task automatic issue_load(input int lane, input int addr, input xfer_sz_t sz,
                              input logic [32:0] want);
        rd_en[lane] = 1'b1;
        rd_addr[lane] = 12'(addr);
        rd_size[lane] = sz;
        exp_q[lane].push_back(want);
    endtask

    // Eight bytes per word, last word commits the length
    task automatic write_packet(input logic pkt);
        int nwords;
        logic [63:0] word;
        nwords = pkt_len(pkt) / 8;
        for (int w = 0; w < nwords; w++) begin
            @(negedge clk);
            for (int b = 0; b < 8; b++) begin
                word[63 - 8 * b -: 8] = byte_of(pkt, 8 * w + b);
            end
            wr_word_en = 1'b1;
            wr_word = word;
            wr_last = (w == nwords - 1);
            wr_bytes = 16'(pkt_len(pkt));
        end
        @(negedge clk);
        wr_word_en = 1'b0;
        wr_last = 1'b0;
        cur_pkt = pkt;
    endtask

    task automatic drain_lanes();
        @(negedge clk);
        rd_en = '0;
        while (lane_busy != '0) begin
            @(negedge clk);
        end
        // Monitor has taken the last result by the next edge
        @(negedge clk);
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            issued_q <= '0;
        end else begin
            issued_q <= rd_en;
        end
    end

    // Scoreboard and busy checks, all outputs settled at the falling edge
    always @(negedge clk) begin
        logic [32:0] want;
        if (rst && out_vld) begin
            assert (exp_q[out_lane].size() != 0) else begin
                $display("Result on lane %0d arrived with no load outstanding", out_lane);
                n_count_err++;
            end
            if (exp_q[out_lane].size() != 0) begin
                want = exp_q[out_lane].pop_front();
                n_checked++;
                assert (out_data == want[31:0] && out_oob == want[32]) else begin
                    $display("** Error at %0t: lane %0d data %h oob %b, expected %h oob %b",
                             $time, out_lane, out_data, out_oob, want[31:0], want[32]);
                    n_value_err++;
                end
            end
            assert (!lane_busy[out_lane]) else begin
                $display("** Error at %0t: lane %0d still busy after its result", $time,
                         out_lane);
                n_busy_err++;
            end
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (issued_q[l]) begin
                assert (lane_busy[l]) else begin
                    $display("** Error at %0t: lane %0d not busy after a load", $time, l);
                    n_busy_err++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int row;
        int issued;
        int addr;
        logic [31:0] r;
        logic [NUM_LANES-1:0] used;
        xfer_sz_t sz;
        rst = 1'b0;
        wr_word_en = 1'b0;
        wr_word = '0;
        wr_last = 1'b0;
        wr_bytes = '0;
        rd_en = '0;
        rd_addr = '0;
        cur_pkt = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            rd_size[l] = BPF_B;
        end
        repeat (5) @(negedge clk);
        rst = 1'b1;
        write_packet(1'b0);

        // Directed rows, packed into one cycle while lanes are free
        row = 0;
        while (row < NUM_ROWS) begin
            if (load_table[row].pkt != cur_pkt) begin
                drain_lanes();
                write_packet(load_table[row].pkt);
            end
            @(negedge clk);
            rd_en = '0;
            used = '0;
            while (row < NUM_ROWS && load_table[row].pkt == cur_pkt
                   && !used[load_table[row].lane] && !lane_busy[load_table[row].lane]) begin
                issue_load(int'(load_table[row].lane), int'(load_table[row].addr),
                           load_table[row].size, {load_table[row].oob, load_table[row].data});
                used[load_table[row].lane] = 1'b1;
                row++;
            end
        end
        drain_lanes();

        // Random loads on the first packet again
        write_packet(1'b0);
        issued = 0;
        while (issued < NUM_RANDOM) begin
            @(negedge clk);
            rd_en = '0;
            for (int l = 0; l < NUM_LANES; l++) begin
                r = $random(seed);
                if (r[0] && !lane_busy[l] && issued < NUM_RANDOM) begin
                    sz = xfer_sz_t'(2'(int'(r[15:12]) % 3));
                    addr = int'(r[11:2]);
                    // Keep every load inside one memory word
                    if (sz == BPF_W && addr % 8 > 4) begin
                        addr -= 4;
                    end
                    if (sz == BPF_H && addr % 8 == 7) begin
                        addr -= 1;
                    end
                    issue_load(l, addr, sz, model_load(cur_pkt, addr, sz));
                    issued++;
                end
            end
        end
        drain_lanes();

        for (int l = 0; l < NUM_LANES; l++) begin
            assert (exp_q[l].size() == 0) else begin
                $display("Lane %0d never delivered %0d results", l, exp_q[l].size());
                n_count_err++;
            end
        end
        $display("Checked %0d results: %0d value errors, %0d busy errors, %0d lost or extra",
                 n_checked, n_value_err, n_busy_err, n_count_err);
        if (n_value_err + n_busy_err + n_count_err == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+testbench
verilog/bpf_pkg.sv
verilog/bpf_ifs.sv
verilog/pkt_writer.sv
verilog/packet_ram.sv
verilog/load_adapter.sv
verilog/read_lane.sv
verilog/result_collector.sv
verilog/bpf_read_array.sv
testbench/tb_bpf_read_array.sv

// ==== Makefile ====
# Verilator build and run of the BPF packet read array testbench

TOP = tb_bpf_read_array
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f

# Pass only when the log holds the pass line
run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module bpf_read_array -f tb.f

clean:
	rm -rf obj_dir $(LOG)
